// File: tl_pkg.sv
`default_nettype none

package tl_pkg;

    // ##############################
    // bus geometry
    // ##############################

    localparam int TL_DATA_BYTES = 4;

    // ##############################
    // channel beats
    // ##############################

    // a-side and d-side opcodes share one encoding space.
    typedef enum logic [2:0] {
        TL_ACCESS_ACK       = 3'd0,
        TL_PUT_PARTIAL_DATA = 3'd1,
        TL_ACCESS_ACK_DATA  = 3'd2,
        TL_GET              = 3'd4
    } tl_opcode_e;

    typedef struct packed {
        tl_opcode_e  opcode;
        logic [3:0]  size;
        logic [31:0] address;
        logic [3:0]  mask;
        logic [31:0] data;
    } tl_a_t;

    typedef struct packed {
        tl_opcode_e  opcode;
        logic [3:0]  size;
        logic        denied;
        logic [31:0] data;
    } tl_d_t;

endpackage

`default_nettype wire

// File: dcache_pkg.sv
`default_nettype none

package dcache_pkg;

    // ##############################
    // request classification
    // ##############################

    typedef enum logic [1:0] {
        REQ_LOAD_CACHED   = 2'd0,
        REQ_LOAD_UNCACHED = 2'd1,
        REQ_STORE         = 2'd2
    } req_kind_e;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // ##############################
    // cpu side
    // ##############################

    // write data arrives low-aligned and decode moves it to its byte lane.
    typedef struct packed {
        logic         write;
        access_size_e size;
        logic [31:0]  addr;
        logic [31:0]  wdata;
        logic [3:0]   be;
    } cpu_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        store_done;
    } cpu_rsp_t;

    // ##############################
    // internal request
    // ##############################

    typedef struct packed {
        req_kind_e    kind;
        logic [29:0]  word_addr;
        logic [1:0]   byte_off;
        access_size_e size;
        logic [31:0]  wdata;
        logic [3:0]   mask;
    } dec_req_t;

endpackage

`default_nettype wire

// File: tl_skid_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module tl_skid_buffer #(
    parameter type payload_t = logic [31:0]
) (
    input  wire logic     cpu_clock_i,
    input  wire logic     arst_n_i,
    input  wire logic     in_valid_i,
    output logic          in_ready_o,
    input  wire payload_t in_data_i,
    output logic          out_valid_o,
    input  wire logic     out_ready_i,
    output payload_t      out_data_o
);
    logic     main_valid_q;
    logic     skid_valid_q;
    payload_t skid_data_q;
    logic     in_fire;
    logic     main_free;

    // ready depends only on the skid slot, so it comes straight from a flop.
    assign in_ready_o  = ~skid_valid_q;
    assign out_valid_o = main_valid_q;
    assign in_fire     = in_valid_i & in_ready_o;
    assign main_free   = ~main_valid_q | out_ready_i;

    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            main_valid_q <= 1'b0;
            skid_valid_q <= 1'b0;
        end else if (main_free) begin
            main_valid_q <= skid_valid_q | in_fire;
            skid_valid_q <= 1'b0;
        end else if (in_fire) begin
            skid_valid_q <= 1'b1;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (main_free) begin
            out_data_o <= skid_valid_q ? skid_data_q : in_data_i;
        end else if (in_fire) begin
            skid_data_q <= in_data_i;
        end
    end

endmodule

`default_nettype wire

// File: dcache_decode.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_decode (
    input  wire logic                 cpu_clock_i,
    input  wire logic                 arst_n_i,
    input  wire logic                 req_i,
    input  wire dcache_pkg::cpu_req_t cpu_req_i,
    input  wire logic                 ack_i,
    output logic                      start_o,
    output dcache_pkg::dec_req_t      dec_req_o
);
    import dcache_pkg::*;

    logic      busy_q;
    logic      new_req;
    logic [1:0] byte_off;
    logic [3:0] mask;
    logic      be_known;
    req_kind_e kind;

    // a request phase is new until the ack of that phase has been seen.
    assign new_req = req_i & ~ack_i & ~busy_q;

    assign kind = cpu_req_i.write    ? REQ_STORE :
                  cpu_req_i.addr[31] ? REQ_LOAD_UNCACHED : REQ_LOAD_CACHED;

    // the byte enable pins down the low address bits and any other enable uses the address.
    always_comb begin
        be_known = 1'b1;
        case (cpu_req_i.be)
            4'b0001: byte_off = 2'd0;
            4'b0010: byte_off = 2'd1;
            4'b0011: byte_off = 2'd0;
            4'b0100: byte_off = 2'd2;
            4'b1100: byte_off = 2'd2;
            4'b1000: byte_off = 2'd3;
            4'b1111: byte_off = 2'd0;
            default: begin
                be_known = 1'b0;
                byte_off = cpu_req_i.addr[1:0];
            end
        endcase
        if (be_known) begin
            mask = cpu_req_i.be;
        end else begin
            case (cpu_req_i.size)
                SIZE_BYTE: mask = 4'b0001 << byte_off;
                SIZE_HALF: mask = 4'b0011 << byte_off;
                default:   mask = 4'b1111;
            endcase
        end
    end

    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            start_o <= 1'b0;
            busy_q  <= 1'b0;
        end else begin
            start_o <= new_req;
            if (new_req) begin
                busy_q <= 1'b1;
            end else if (ack_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (new_req) begin
            dec_req_o.kind      <= kind;
            dec_req_o.word_addr <= cpu_req_i.addr[31:2];
            dec_req_o.byte_off  <= byte_off;
            dec_req_o.size      <= cpu_req_i.size;
            dec_req_o.wdata     <= cpu_req_i.wdata << {byte_off, 3'b000};
            dec_req_o.mask      <= mask;
        end
    end

endmodule

`default_nettype wire

// File: dcache_execute.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_execute #(
    parameter int SETS       = 32,
    parameter int LINE_WORDS = 8
) (
    input  wire logic                 cpu_clock_i,
    input  wire logic                 arst_n_i,
    input  wire logic                 start_i,
    input  wire dcache_pkg::dec_req_t dec_req_i,
    output logic                      done_o,
    output logic [31:0]               word_o,
    output logic                      a_valid_o,
    input  wire logic                 a_ready_i,
    output tl_pkg::tl_a_t             a_beat_o,
    input  wire logic                 d_valid_i,
    output logic                      d_ready_o,
    input  wire tl_pkg::tl_d_t        d_beat_i
);
    import dcache_pkg::*;
    import tl_pkg::*;

    localparam int WORD_BITS = $clog2(LINE_WORDS);
    localparam int SET_BITS  = $clog2(SETS);
    localparam int TAG_BITS  = 30 - WORD_BITS - SET_BITS;
    localparam logic [3:0] LINE_SIZE = 4'($clog2(LINE_WORDS * TL_DATA_BYTES));

    typedef enum logic [2:0] {
        S_IDLE, S_LOOKUP, S_MISS_REQ, S_FILL, S_UNC_WAIT, S_STORE_WAIT, S_DONE
    } state_e;

    state_e state_q;

    logic [TAG_BITS-1:0] tag_q  [0:1][0:SETS-1];
    logic [31:0]         data_q [0:1][0:SETS*LINE_WORDS-1];
    logic [SETS-1:0]     valid_q [0:1];

    logic                 rr_q;
    logic                 victim_q;
    logic [WORD_BITS-1:0] beat_q;
    logic [31:0]          rdata_q;

    logic [TAG_BITS-1:0]  req_tag;
    logic [SET_BITS-1:0]  req_set;
    logic [WORD_BITS-1:0] req_word;
    logic [1:0]           way_hit;
    logic                 hit;
    logic                 hit_way;
    logic                 victim;
    logic [31:0]          hit_word;
    logic                 last_beat;
    logic                 fill_we;
    logic                 store_we;

    // ##############################
    // lookup
    // ##############################

    assign req_tag  = dec_req_i.word_addr[29 -: TAG_BITS];
    assign req_set  = dec_req_i.word_addr[WORD_BITS +: SET_BITS];
    assign req_word = dec_req_i.word_addr[WORD_BITS-1:0];

    assign way_hit[0] = valid_q[0][req_set] && (tag_q[0][req_set] == req_tag);
    assign way_hit[1] = valid_q[1][req_set] && (tag_q[1][req_set] == req_tag);
    assign hit        = (dec_req_i.kind != REQ_LOAD_UNCACHED) && (|way_hit);
    assign hit_way    = way_hit[1];
    assign hit_word   = data_q[hit_way][{req_set, req_word}];

    // an empty way wins, otherwise the round-robin pointer decides.
    assign victim = !valid_q[0][req_set] ? 1'b0 :
                    !valid_q[1][req_set] ? 1'b1 : rr_q;

    assign last_beat = (beat_q == WORD_BITS'(LINE_WORDS - 1));
    assign fill_we   = (state_q == S_FILL) && d_valid_i;
    assign store_we  = (state_q == S_LOOKUP) && (dec_req_i.kind == REQ_STORE) && hit;

    assign done_o = (state_q == S_DONE) ||
                    ((state_q == S_LOOKUP) && (dec_req_i.kind == REQ_LOAD_CACHED) && hit);
    assign word_o = (state_q == S_LOOKUP) ? hit_word : rdata_q;

    assign a_valid_o = (state_q == S_MISS_REQ);
    assign d_ready_o = (state_q == S_FILL) || (state_q == S_UNC_WAIT) ||
                       (state_q == S_STORE_WAIT);

    always_comb begin
        a_beat_o.opcode  = TL_GET;
        a_beat_o.size    = 4'd2;
        a_beat_o.address = {dec_req_i.word_addr, 2'b00};
        a_beat_o.mask    = 4'hF;
        a_beat_o.data    = '0;
        case (dec_req_i.kind)
            REQ_LOAD_CACHED: begin
                a_beat_o.size    = LINE_SIZE;
                a_beat_o.address = {dec_req_i.word_addr[29:WORD_BITS],
                                    {WORD_BITS{1'b0}}, 2'b00};
            end
            REQ_STORE: begin
                a_beat_o.opcode = TL_PUT_PARTIAL_DATA;
                a_beat_o.mask   = dec_req_i.mask;
                a_beat_o.data   = dec_req_i.wdata;
            end
            default: ;
        endcase
    end

    // ##############################
    // controller
    // ##############################

    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q    <= S_IDLE;
            rr_q       <= 1'b0;
            victim_q   <= 1'b0;
            beat_q     <= '0;
            valid_q[0] <= '0;
            valid_q[1] <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (start_i) begin
                        state_q <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (dec_req_i.kind == REQ_LOAD_CACHED && hit) begin
                        state_q <= S_IDLE;
                    end else begin
                        state_q <= S_MISS_REQ;
                    end
                    // the victim line is dropped before the refill overwrites it.
                    if (dec_req_i.kind == REQ_LOAD_CACHED && !hit) begin
                        victim_q                <= victim;
                        valid_q[victim][req_set] <= 1'b0;
                    end
                end
                S_MISS_REQ: begin
                    if (a_ready_i) begin
                        beat_q <= '0;
                        case (dec_req_i.kind)
                            REQ_LOAD_CACHED:   state_q <= S_FILL;
                            REQ_LOAD_UNCACHED: state_q <= S_UNC_WAIT;
                            default:           state_q <= S_STORE_WAIT;
                        endcase
                    end
                end
                S_FILL: begin
                    if (d_valid_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat) begin
                            valid_q[victim_q][req_set] <= 1'b1;
                            rr_q    <= ~rr_q;
                            state_q <= S_DONE;
                        end
                    end
                end
                S_UNC_WAIT, S_STORE_WAIT: begin
                    if (d_valid_i) begin
                        state_q <= S_DONE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (fill_we) begin
            data_q[victim_q][{req_set, beat_q}] <= d_beat_i.data;
            if (last_beat) begin
                tag_q[victim_q][req_set] <= req_tag;
            end
        end else if (store_we) begin
            for (int b = 0; b < 4; b++) begin
                if (dec_req_i.mask[b]) begin
                    data_q[hit_way][{req_set, req_word}][8*b +: 8] <= dec_req_i.wdata[8*b +: 8];
                end
            end
        end
        if ((fill_we && beat_q == req_word) || (state_q == S_UNC_WAIT && d_valid_i)) begin
            rdata_q <= d_beat_i.data;
        end
    end

endmodule

`default_nettype wire

// File: dcache_result.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_result (
    input  wire logic                 cpu_clock_i,
    input  wire logic                 arst_n_i,
    input  wire logic                 done_i,
    input  wire logic [31:0]          word_i,
    input  wire dcache_pkg::dec_req_t dec_req_i,
    input  wire logic                 req_i,
    output logic                      ack_o,
    output dcache_pkg::cpu_rsp_t      cpu_rsp_o
);
    import dcache_pkg::*;

    logic [31:0] shifted;
    logic [31:0] load_data;

    // move the addressed lane down to bit 0.
    assign shifted = word_i >> {dec_req_i.byte_off, 3'b000};

    always_comb begin
        case (dec_req_i.size)
            SIZE_BYTE: load_data = {24'h000000, shifted[7:0]};
            SIZE_HALF: load_data = {16'h0000, shifted[15:0]};
            default:   load_data = word_i;
        endcase
    end

    // ack stays up for as long as the cpu keeps req high.
    always_ff @(posedge cpu_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o <= 1'b0;
        end else if (done_i) begin
            ack_o <= 1'b1;
        end else if (ack_o && !req_i) begin
            ack_o <= 1'b0;
        end
    end

    always_ff @(posedge cpu_clock_i) begin
        if (done_i) begin
            cpu_rsp_o.rdata      <= load_data;
            cpu_rsp_o.store_done <= (dec_req_i.kind == REQ_STORE);
        end
    end

endmodule

`default_nettype wire

// File: dcache_top.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_top #(
    parameter int SETS       = 32,
    parameter int LINE_WORDS = 8
) (
    input  wire logic                 cpu_clock_i,
    input  wire logic                 arst_n_i,
    input  wire logic                 req_i,
    input  wire dcache_pkg::cpu_req_t cpu_req_i,
    output logic                      ack_o,
    output dcache_pkg::cpu_rsp_t      cpu_rsp_o,
    output logic                      a_valid_o,
    input  wire logic                 a_ready_i,
    output tl_pkg::tl_a_t             a_beat_o,
    input  wire logic                 d_valid_i,
    output logic                      d_ready_o,
    input  wire tl_pkg::tl_d_t        d_beat_i
);
    import dcache_pkg::*;
    import tl_pkg::*;

    logic        start;
    dec_req_t    dec_req;
    logic        done;
    logic [31:0] word;
    logic        ex_a_valid;
    logic        ex_a_ready;
    tl_a_t       ex_a_beat;
    logic        ex_d_valid;
    logic        ex_d_ready;
    tl_d_t       ex_d_beat;

    dcache_decode dcache_decode_inst (
        .cpu_clock_i (cpu_clock_i),
        .arst_n_i    (arst_n_i),
        .req_i       (req_i),
        .cpu_req_i   (cpu_req_i),
        .ack_i       (ack_o),
        .start_o     (start),
        .dec_req_o   (dec_req)
    );

    dcache_execute #(
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) dcache_execute_inst (
        .cpu_clock_i (cpu_clock_i),
        .arst_n_i    (arst_n_i),
        .start_i     (start),
        .dec_req_i   (dec_req),
        .done_o      (done),
        .word_o      (word),
        .a_valid_o   (ex_a_valid),
        .a_ready_i   (ex_a_ready),
        .a_beat_o    (ex_a_beat),
        .d_valid_i   (ex_d_valid),
        .d_ready_o   (ex_d_ready),
        .d_beat_i    (ex_d_beat)
    );

    dcache_result dcache_result_inst (
        .cpu_clock_i (cpu_clock_i),
        .arst_n_i    (arst_n_i),
        .done_i      (done),
        .word_i      (word),
        .dec_req_i   (dec_req),
        .req_i       (req_i),
        .ack_o       (ack_o),
        .cpu_rsp_o   (cpu_rsp_o)
    );

    // ##############################
    // bus channel buffers
    // ##############################

    tl_skid_buffer #(.payload_t(tl_a_t)) a_skid_inst (
        .cpu_clock_i (cpu_clock_i),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (ex_a_valid),
        .in_ready_o  (ex_a_ready),
        .in_data_i   (ex_a_beat),
        .out_valid_o (a_valid_o),
        .out_ready_i (a_ready_i),
        .out_data_o  (a_beat_o)
    );

    tl_skid_buffer #(.payload_t(tl_d_t)) d_skid_inst (
        .cpu_clock_i (cpu_clock_i),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (d_valid_i),
        .in_ready_o  (d_ready_o),
        .in_data_i   (d_beat_i),
        .out_valid_o (ex_d_valid),
        .out_ready_i (ex_d_ready),
        .out_data_o  (ex_d_beat)
    );

endmodule

`default_nettype wire

// File: tb_tl_mem.sv
`timescale 1ns/10ps
`default_nettype none

module tb_tl_mem (
    input  wire logic          cpu_clock_i,
    input  wire logic          a_valid_i,
    output logic               a_ready_o,
    input  wire tl_pkg::tl_a_t a_beat_i,
    output logic               d_valid_o,
    input  wire logic          d_ready_i,
    output tl_pkg::tl_d_t      d_beat_o
);
    import tl_pkg::*;

    localparam int WORDS = 1024;

    // 4 KB of storage that decodes address bits 11:2 only.
    logic [31:0] mem [0:WORDS-1];
    tl_d_t       d_queue [$];
    integer      seed;
    int          get_count;

    initial begin
        seed      = 73661;
        get_count = 0;
        a_ready_o = 1'b0;
        d_valid_o = 1'b0;
        d_beat_o  = '0;
        for (int i = 0; i < WORDS; i++) begin
            mem[i[9:0]] = 32'(i * 4) ^ 32'hA5A50000;
        end
    end

    task automatic accept_beat(input tl_a_t beat);
        tl_d_t       rsp;
        logic [9:0]  idx;
        logic [31:0] bitmask;
        int          beats;
        idx     = beat.address[11:2];
        rsp     = '0;
        bitmask = {{8{beat.mask[3]}}, {8{beat.mask[2]}}, {8{beat.mask[1]}}, {8{beat.mask[0]}}};
        if (beat.opcode == TL_GET) begin
            get_count++;
            beats      = (beat.size > 4'd2) ? (1 << (beat.size - 4'd2)) : 1;
            rsp.opcode = TL_ACCESS_ACK_DATA;
            rsp.size   = beat.size;
            // a burst answers in address order from the aligned base.
            for (int k = 0; k < beats; k++) begin
                rsp.data = mem[idx + 10'(k)];
                d_queue.push_back(rsp);
            end
        end else begin
            mem[idx]   = (mem[idx] & ~bitmask) | (beat.data & bitmask);
            rsp.opcode = TL_ACCESS_ACK;
            rsp.size   = beat.size;
            d_queue.push_back(rsp);
        end
    endtask

    always begin : bus_loop
        logic  a_fire;
        logic  d_fire;
        tl_a_t a_seen;
        @(negedge cpu_clock_i);
        a_fire = a_valid_i && a_ready_o;
        d_fire = d_valid_o && d_ready_i;
        a_seen = a_beat_i;
        @(posedge cpu_clock_i);
        #2;
        if (d_fire) begin
            void'(d_queue.pop_front());
        end
        if (a_fire) begin
            accept_beat(a_seen);
        end
        a_ready_o = ($random(seed) & 3) != 0;
        d_valid_o = (d_queue.size() > 0);
        if (d_queue.size() > 0) begin
            d_beat_o = d_queue[0];
        end else begin
            d_beat_o = '0;
        end
    end

endmodule

`default_nettype wire

// File: dcache_sva.sv
`timescale 1ns/10ps
`default_nettype none

module dcache_sva (
    input wire logic          cpu_clock_i,
    input wire logic          arst_n_i,
    input wire logic          req_i,
    input wire logic          ack_i,
    input wire logic          a_valid_i,
    input wire logic          a_ready_i,
    input wire tl_pkg::tl_a_t a_beat_i
);

    // ack only ever answers a pending request.
    ack_needs_req: assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i)
        $rose(ack_i) |-> req_i)
        else $error("ack_o rose while req_i was low");

    a_beat_held: assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i)
        (a_valid_i && !a_ready_i) |=> (a_valid_i && $stable(a_beat_i)))
        else $error("a-channel beat dropped or changed before a_ready_i");

    ack_falls_after_req: assert property (@(posedge cpu_clock_i) disable iff (!arst_n_i)
        $fell(ack_i) |-> !$past(req_i))
        else $error("ack_o fell while req_i was still high");

endmodule

bind dcache_top dcache_sva dcache_sva_inst (
    .cpu_clock_i (cpu_clock_i),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .ack_i       (ack_o),
    .a_valid_i   (a_valid_o),
    .a_ready_i   (a_ready_i),
    .a_beat_i    (a_beat_o)
);

`default_nettype wire

// File: tb_dcache.sv
`timescale 1ns/10ps
`default_nettype none

module tb_dcache;
    import dcache_pkg::*;
    import tl_pkg::*;

    localparam int SETS              = 32;
    localparam int LINE_WORDS        = 8;
    localparam int CLK_PERIOD        = 20;
    localparam int RESET_CYCLES      = 16;
    localparam int DRIVE_DELAY       = 2;
    localparam int RECORD_FIELDS     = 5;
    localparam int MAX_RECORDS       = 100;
    localparam int CYCLES_PER_RECORD = 400;
    localparam logic [7:0] END_OP    = 8'hFF;

    // get-count rules held in the top two bits of the op field.
    localparam logic [1:0] GETS_ANY  = 2'd0;
    localparam logic [1:0] GETS_NONE = 2'd1;
    localparam logic [1:0] GETS_ONE  = 2'd2;
    localparam logic [1:0] GETS_SOME = 2'd3;

    logic        cpu_clock = 1'b0;
    logic        arst_n;
    logic        req;
    cpu_req_t    cpu_req;
    logic        ack;
    cpu_rsp_t    cpu_rsp;
    logic        a_valid;
    logic        a_ready;
    tl_a_t       a_beat;
    logic        d_valid;
    logic        d_ready;
    tl_d_t       d_beat;

    logic [31:0] pattern_mem [0:511];
    int          num_records;
    logic        records_loaded = 1'b0;

    always #(CLK_PERIOD / 2) cpu_clock = ~cpu_clock;

    dcache_top #(
        .SETS       (SETS),
        .LINE_WORDS (LINE_WORDS)
    ) dcache_top_inst (
        .cpu_clock_i (cpu_clock),
        .arst_n_i    (arst_n),
        .req_i       (req),
        .cpu_req_i   (cpu_req),
        .ack_o       (ack),
        .cpu_rsp_o   (cpu_rsp),
        .a_valid_o   (a_valid),
        .a_ready_i   (a_ready),
        .a_beat_o    (a_beat),
        .d_valid_i   (d_valid),
        .d_ready_o   (d_ready),
        .d_beat_i    (d_beat)
    );

    tb_tl_mem tl_mem_inst (
        .cpu_clock_i (cpu_clock),
        .a_valid_i   (a_valid),
        .a_ready_o   (a_ready),
        .a_beat_i    (a_beat),
        .d_valid_o   (d_valid),
        .d_ready_i   (d_ready),
        .d_beat_o    (d_beat)
    );

    // ##############################
    // compare tasks
    // ##############################

    task automatic check_load(input cpu_rsp_t rsp, input logic [31:0] expected,
                              input logic [31:0] addr);
        if (rsp.rdata !== expected) begin
            $display("MISMATCH cpu_rsp_o.rdata at %08h: got %08h, expected %08h",
                     addr, rsp.rdata, expected);
            $display("** FAIL **");
            $fatal(1, "load data differs");
        end
        if (rsp.store_done !== 1'b0) begin
            $display("MISMATCH cpu_rsp_o.store_done at %08h: got %h, expected 0",
                     addr, rsp.store_done);
            $display("** FAIL **");
            $fatal(1, "store-done set on a load");
        end
    endtask

    task automatic check_store(input cpu_rsp_t rsp, input logic [31:0] addr);
        if (rsp.store_done !== 1'b1) begin
            $display("MISMATCH cpu_rsp_o.store_done at %08h: got %h, expected 1",
                     addr, rsp.store_done);
            $display("** FAIL **");
            $fatal(1, "store-done missing");
        end
    endtask

    task automatic check_get_count(input logic [1:0] rule, input int new_gets,
                                   input logic [31:0] addr);
        logic  ok;
        string expected;
        case (rule)
            GETS_NONE: begin
                ok       = (new_gets == 0);
                expected = "00000000";
            end
            GETS_ONE: begin
                ok       = (new_gets == 1);
                expected = "00000001";
            end
            GETS_SOME: begin
                ok       = (new_gets >= 1);
                expected = "at least 00000001";
            end
            GETS_ANY: begin
                ok       = 1'b1;
                expected = "any";
            end
        endcase
        if (!ok) begin
            $display("MISMATCH get_count delta at %08h: got %08h, expected %s",
                     addr, new_gets, expected);
            $display("** FAIL **");
            $fatal(1, "bus Get count differs");
        end
    endtask

    // ##############################
    // stimulus
    // ##############################

    task automatic load_patterns();
        logic [8:0] base;
        $readmemh("dcache_patterns.hex", pattern_mem);
        num_records = 0;
        base        = 9'd0;
        while (num_records < MAX_RECORDS && pattern_mem[base][7:0] !== END_OP) begin
            num_records++;
            base = base + 9'(RECORD_FIELDS);
        end
        if (num_records == 0 || num_records == MAX_RECORDS) begin
            $display("the pattern file is empty or has no end record");
            $display("** FAIL **");
            $fatal(1, "bad pattern file");
        end
    endtask

    task automatic wait_for_ack(input logic level);
        do begin
            @(negedge cpu_clock);
        end while (ack !== level);
    endtask

    // runs one full four-phase cycle and takes the response while ack is high.
    task automatic request_cycle(input cpu_req_t creq, output cpu_rsp_t rsp);
        @(posedge cpu_clock);
        #DRIVE_DELAY;
        cpu_req = creq;
        req     = 1'b1;
        wait_for_ack(1'b1);
        rsp = cpu_rsp;
        @(posedge cpu_clock);
        #DRIVE_DELAY;
        req = 1'b0;
        wait_for_ack(1'b0);
    endtask

    task automatic run_record(input int rec);
        logic [8:0]  base;
        logic [7:0]  op;
        logic [31:0] expected;
        cpu_req_t    creq;
        cpu_rsp_t    rsp;
        int          gets_before;
        base        = 9'(rec * RECORD_FIELDS);
        op          = pattern_mem[base][7:0];
        creq.write  = op[4];
        creq.size   = access_size_e'(op[1:0]);
        creq.addr   = pattern_mem[base + 9'd1];
        creq.wdata  = pattern_mem[base + 9'd2];
        creq.be     = pattern_mem[base + 9'd3][3:0];
        expected    = pattern_mem[base + 9'd4];
        gets_before = tl_mem_inst.get_count;
        request_cycle(creq, rsp);
        if (creq.write) begin
            check_store(rsp, creq.addr);
        end else begin
            check_load(rsp, expected, creq.addr);
        end
        check_get_count(op[7:6], tl_mem_inst.get_count - gets_before, creq.addr);
    endtask

    initial begin : stimulus
        arst_n  = 1'b0;
        req     = 1'b0;
        cpu_req = '0;
        load_patterns();
        records_loaded = 1'b1;
        repeat (RESET_CYCLES) @(posedge cpu_clock);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        for (int rec = 0; rec < num_records; rec++) begin
            run_record(rec);
        end
        $display("** PASS **");
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (records_loaded);
        limit = RESET_CYCLES + num_records * CYCLES_PER_RECORD;
        repeat (limit) @(posedge cpu_clock);
        $display("timeout after %0d cycles with %0d records", limit, num_records);
        $display("** FAIL **");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

// File: dcache_patterns.hex
// columns: op addr wdata be expected
// op [7:6] get rule (0 any, 1 none, 2 one, 3 at least one), [4] store, [1:0] size; ff ends
82 00000010 00000000 F A5A50010
41 00000012 00000000 C 0000A5A5
40 00000013 00000000 8 000000A5
40 0000001C 00000000 1 0000001C
81 00000024 00000000 3 00000024
50 00000011 0000005A 2 00000000
42 00000010 00000000 F A5A55A10
52 00000014 12345678 F 00000000
42 00000014 00000000 F 12345678
51 00000102 0000BEEF C 00000000
82 00000100 00000000 F BEEF0100
82 80000040 00000000 F A5A50040
82 80000040 00000000 F A5A50040
80 80000043 00000000 8 000000A5
82 00000040 00000000 F A5A50040
82 00000080 00000000 F A5A50080
82 00000480 00000000 F A5A50480
82 00000884 00000000 F A5A50884
C2 00000080 00000000 F A5A50080
02 00000480 00000000 F A5A50480
02 00000884 00000000 F A5A50884
FF 00000000 00000000 0 00000000

// File: flist.f
tl_pkg.sv
dcache_pkg.sv
tl_skid_buffer.sv
dcache_decode.sv
dcache_execute.sv
dcache_result.sv
dcache_top.sv
tb_tl_mem.sv
dcache_sva.sv
tb_dcache.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/10ps
TOP       := tb_dcache
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FLIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM) dcache_patterns.hex
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
